// ==== dma_ep_defs.svh ====
// width and depth macros for the dma endpoint transmit path
// include in every file that sizes a word, an address or a request queue
`ifndef DMA_EP_DEFS_SVH
`define DMA_EP_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// endpoint port
////////////////////////////////////////////////////////////////////////////

`define DMA_EP_WORD_W 64 // one tx word per cycle

////////////////////////////////////////////////////////////////////////////
// request side
////////////////////////////////////////////////////////////////////////////

`define DMA_EP_ADDR_W 32 // 32-bit addressing only, no 4dw headers
`define DMA_EP_QUEUE_DEPTH 4 // entries per request queue

`endif

// ==== dma_ep_pkg.sv ====
// shared types for the dma endpoint transmit path
// referenced by scoped name, dma_ep_pkg::<name>
package dma_ep_pkg;

    // packet type, top nibble of every header word
    // values follow the fmt/type byte upper nibble of the pcie tlp
    typedef enum logic [3:0] {
        TLP_MRD = 4'h0, // memory read, no data
        TLP_MSG = 4'h3, // message, interrupt vector in low bits
        TLP_MWR = 4'h4 // memory write, one data word follows
    } tlp_type_e;

    // transmit arbiter states
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0, // wait for all engines idle, then hand out rd/wr turn
        ARB_GRANT = 2'd1, // turn strobe is high this cycle
        ARB_IRQ_WAIT = 2'd2, // interrupt slot pending, wait for rd/wr packet to end
        ARB_IRQ_GRANT = 2'd3 // irq turn strobe is high this cycle
    } arb_state_e;

endpackage

// ==== ep_arbiter.sv ====
// transmit arbiter in front of the endpoint port
// alternates turns between read and write engines, slips in an irq slot on demand
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module ep_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // engine busy flags
    input  logic                      wr_drvn,
    input  logic                      rd_drvn,
    input  logic                      irq_drvn,
    input  logic                      irq_reqep, // irq engine has a message waiting
    // write engine word bus
    input  logic                      wr_word_valid,
    input  logic [`DMA_EP_WORD_W-1:0] wr_word_data,
    input  logic                      wr_word_last,
    // read engine word bus
    input  logic                      rd_word_valid,
    input  logic [`DMA_EP_WORD_W-1:0] rd_word_data,
    input  logic                      rd_word_last,
    // irq engine word bus
    input  logic                      irq_word_valid,
    input  logic [`DMA_EP_WORD_W-1:0] irq_word_data,
    input  logic                      irq_word_last,
    // turn strobes, one cycle each
    output logic                      wr_trn,
    output logic                      rd_trn,
    output logic                      irq_trn,
    // endpoint tx port, always ready
    output logic                      ep_valid,
    output logic [`DMA_EP_WORD_W-1:0] ep_data,
    output logic                      ep_last
);

    // owner codes
    localparam logic [1:0] OWN_NONE = 2'd0; // only after reset
    localparam logic [1:0] OWN_WR   = 2'd1;
    localparam logic [1:0] OWN_RD   = 2'd2;
    localparam logic [1:0] OWN_IRQ  = 2'd3;

    dma_ep_pkg::arb_state_e state;
    logic                   turn_bit; // 0 -> read next, 1 -> write next
    logic [1:0]             owner;    // engine holding the port

    ////////////////////////////////////////////////////////////////////////////
    // turn fsm
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dma_ep_pkg::ARB_IDLE;
            turn_bit <= 1'b0;
            owner    <= OWN_NONE;
            wr_trn   <= 1'b0;
            rd_trn   <= 1'b0;
            irq_trn  <= 1'b0;
        end else begin
            case (state)
                dma_ep_pkg::ARB_IDLE: begin
                    // previous packet must be fully out
                    if (!wr_drvn && !rd_drvn && !irq_drvn) begin
                        turn_bit <= ~turn_bit;
                        if (!turn_bit) begin
                            rd_trn <= 1'b1;
                            owner  <= OWN_RD;
                        end else begin
                            wr_trn <= 1'b1;
                            owner  <= OWN_WR;
                        end
                        state <= dma_ep_pkg::ARB_GRANT;
                    end
                end
                dma_ep_pkg::ARB_GRANT: begin
                    wr_trn <= 1'b0; // single-cycle strobe
                    rd_trn <= 1'b0;
                    if (irq_reqep) begin
                        state <= dma_ep_pkg::ARB_IRQ_WAIT;
                    end else begin
                        state <= dma_ep_pkg::ARB_IDLE; // idle then waits on drvn
                    end
                end
                dma_ep_pkg::ARB_IRQ_WAIT: begin
                    // never cut into a rd/wr packet
                    if (!wr_drvn && !rd_drvn) begin
                        irq_trn <= 1'b1;
                        owner   <= OWN_IRQ;
                        state   <= dma_ep_pkg::ARB_IRQ_GRANT;
                    end
                end
                dma_ep_pkg::ARB_IRQ_GRANT: begin
                    irq_trn <= 1'b0;
                    state   <= dma_ep_pkg::ARB_IDLE;
                end
                default: begin
                    state <= dma_ep_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // endpoint mux, no register stage
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (owner)
            OWN_WR: begin
                ep_valid = wr_word_valid;
                ep_data  = wr_word_data;
                ep_last  = wr_word_last;
            end
            OWN_RD: begin
                ep_valid = rd_word_valid;
                ep_data  = rd_word_data;
                ep_last  = rd_word_last;
            end
            OWN_IRQ: begin
                ep_valid = irq_word_valid;
                ep_data  = irq_word_data;
                ep_last  = irq_word_last;
            end
            default: begin // nobody granted yet
                ep_valid = 1'b0;
                ep_data  = '0;
                ep_last  = 1'b0;
            end
        endcase
    end

endmodule

// ==== wr_tlp_engine.sv ====
// memory-write engine, queues user write requests
// on its turn sends a mwr header word then the data word
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module wr_tlp_engine (
    input  logic                        clk,
    input  logic                        rst,
    // user request, single-cycle strobe
    input  logic                        wr_req,
    input  logic [`DMA_EP_ADDR_W-1:0]   wr_addr,
    input  logic [`DMA_EP_WORD_W/2-1:0] wr_data,
    input  logic [3:0]                  wr_tag,
    input  logic                        wr_trn,        // turn from arbiter
    output logic                        wr_overflow,   // strobe dropped, queue full
    output logic                        wr_drvn,       // packet in flight
    output logic                        wr_word_valid,
    output logic [`DMA_EP_WORD_W-1:0]   wr_word_data,
    output logic                        wr_word_last
);

    localparam int PTR_W = $clog2(`DMA_EP_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`DMA_EP_QUEUE_DEPTH + 1);
    localparam int PAD_W = `DMA_EP_WORD_W - 8 - `DMA_EP_ADDR_W; // header bits 55:32

    // queue storage
    logic [`DMA_EP_ADDR_W-1:0]   addr_mem [`DMA_EP_QUEUE_DEPTH];
    logic [`DMA_EP_WORD_W/2-1:0] data_mem [`DMA_EP_QUEUE_DEPTH];
    logic [3:0]                  tag_mem  [`DMA_EP_QUEUE_DEPTH];

    logic [PTR_W-1:0]            head;
    logic [PTR_W-1:0]            tail;
    logic [CNT_W-1:0]            count;
    logic [`DMA_EP_WORD_W/2-1:0] data_hold; // payload for the second beat
    logic                        full;
    logic                        pop;
    logic                        push;

    assign full = (count == CNT_W'(`DMA_EP_QUEUE_DEPTH));
    assign pop  = wr_trn && !wr_drvn && (count != '0); // turn taken
    assign push = wr_req && (!full || pop); // pop frees the slot this cycle

    ////////////////////////////////////////////////////////////////////////////
    // queue
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail] <= wr_addr;
            data_mem[tail] <= wr_data;
            tag_mem[tail]  <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            wr_overflow <= 1'b0;
        end else begin
            wr_overflow <= wr_req && !push; // one-cycle pulse
            if (push) begin
                tail <= (tail == PTR_W'(`DMA_EP_QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(`DMA_EP_QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet out, header beat then data beat
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_drvn       <= 1'b0;
            wr_word_valid <= 1'b0;
            wr_word_last  <= 1'b0;
        end else if (pop) begin
            wr_drvn       <= 1'b1;
            wr_word_valid <= 1'b1;
            wr_word_last  <= 1'b0;
        end else if (wr_drvn && !wr_word_last) begin
            wr_word_last  <= 1'b1; // data beat
        end else if (wr_drvn) begin
            wr_drvn       <= 1'b0; // last beat went out
            wr_word_valid <= 1'b0;
            wr_word_last  <= 1'b0;
        end
    end

    // word payload, no reset needed
    always_ff @(posedge clk) begin
        if (pop) begin
            wr_word_data <= {dma_ep_pkg::TLP_MWR, tag_mem[head], {PAD_W{1'b0}}, addr_mem[head]};
            data_hold    <= data_mem[head];
        end else if (wr_drvn && !wr_word_last) begin
            wr_word_data <= {{(`DMA_EP_WORD_W/2){1'b0}}, data_hold}; // payload in low half
        end
    end

endmodule

// ==== rd_tlp_engine.sv ====
// memory-read-request engine, queues user read requests
// on its turn sends one mrd header word, completions are not handled here
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module rd_tlp_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rd_req,   // single-cycle strobe
    input  logic [`DMA_EP_ADDR_W-1:0] rd_addr,
    input  logic [3:0]                rd_tag,
    input  logic                      rd_trn,   // turn from arbiter
    output logic                      rd_overflow,
    output logic                      rd_drvn,
    output logic                      rd_word_valid,
    output logic [`DMA_EP_WORD_W-1:0] rd_word_data,
    output logic                      rd_word_last
);

    localparam int PTR_W = $clog2(`DMA_EP_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`DMA_EP_QUEUE_DEPTH + 1);
    localparam int PAD_W = `DMA_EP_WORD_W - 8 - `DMA_EP_ADDR_W;

    logic [`DMA_EP_ADDR_W-1:0] addr_mem [`DMA_EP_QUEUE_DEPTH];
    logic [3:0]                tag_mem  [`DMA_EP_QUEUE_DEPTH];

    logic [PTR_W-1:0]          head;
    logic [PTR_W-1:0]          tail;
    logic [CNT_W-1:0]          count;
    logic                      full;
    logic                      pop;
    logic                      push;

    assign full = (count == CNT_W'(`DMA_EP_QUEUE_DEPTH));
    assign pop  = rd_trn && !rd_drvn && (count != '0);
    assign push = rd_req && (!full || pop);

    // queue storage
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail] <= rd_addr;
            tag_mem[tail]  <= rd_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            rd_overflow <= 1'b0;
        end else begin
            rd_overflow <= rd_req && !push; // dropped request
            if (push) begin
                tail <= (tail == PTR_W'(`DMA_EP_QUEUE_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(`DMA_EP_QUEUE_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // single-beat packet
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_drvn       <= 1'b0;
            rd_word_valid <= 1'b0;
            rd_word_last  <= 1'b0;
        end else begin
            rd_drvn       <= pop; // high for exactly the header cycle
            rd_word_valid <= pop;
            rd_word_last  <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rd_word_data <= {dma_ep_pkg::TLP_MRD, tag_mem[head], {PAD_W{1'b0}}, addr_mem[head]};
        end
    end

endmodule

// ==== irq_msg_engine.sv ====
// interrupt message engine, one pending vector, last strobe wins
// raises irq_reqep so the arbiter adds an irq slot after the current rd/wr slot
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module irq_msg_engine (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      irq_req,
    input  logic [7:0]                irq_vector,
    input  logic                      irq_trn,
    output logic                      irq_reqep, // message pending
    output logic                      irq_drvn,
    output logic                      irq_word_valid,
    output logic [`DMA_EP_WORD_W-1:0] irq_word_data,
    output logic                      irq_word_last
);

    logic [7:0] vector_q; // latest vector
    logic       send;

    assign send = irq_trn && irq_reqep; // turn with something pending

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_reqep      <= 1'b0;
            irq_drvn       <= 1'b0;
            irq_word_valid <= 1'b0;
            irq_word_last  <= 1'b0;
        end else begin
            if (irq_req) begin
                irq_reqep <= 1'b1; // also re-arms on a send cycle
            end else if (send) begin
                irq_reqep <= 1'b0;
            end
            irq_drvn       <= send; // one-word message
            irq_word_valid <= send;
            irq_word_last  <= send;
        end
    end

    // vector and message word
    always_ff @(posedge clk) begin
        if (irq_req) begin
            vector_q <= irq_vector; // overwrite, one message only
        end
        if (send) begin
            // tag zero, vector zero-extended into the address field
            irq_word_data <= {dma_ep_pkg::TLP_MSG, 4'h0, {(`DMA_EP_WORD_W-16){1'b0}}, vector_q};
        end
    end

endmodule

// ==== dma_ep_top.sv ====
// dma endpoint transmit subsystem
// three packet engines share the endpoint tx port through ep_arbiter
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module dma_ep_top (
    input  logic                        clk,
    input  logic                        rst,
    // write requests
    input  logic                        wr_req,
    input  logic [`DMA_EP_ADDR_W-1:0]   wr_addr,
    input  logic [`DMA_EP_WORD_W/2-1:0] wr_data,
    input  logic [3:0]                  wr_tag,
    // read requests
    input  logic                        rd_req,
    input  logic [`DMA_EP_ADDR_W-1:0]   rd_addr,
    input  logic [3:0]                  rd_tag,
    // interrupt requests
    input  logic                        irq_req,
    input  logic [7:0]                  irq_vector,
    output logic                        wr_overflow,
    output logic                        rd_overflow,
    // endpoint tx port
    output logic                        ep_valid,
    output logic [`DMA_EP_WORD_W-1:0]   ep_data,
    output logic                        ep_last
);

    ////////////////////////////////////////////////////////////////////////////
    // engine <-> arbiter
    ////////////////////////////////////////////////////////////////////////////

    logic                      wr_trn, rd_trn, irq_trn;
    logic                      wr_drvn, rd_drvn, irq_drvn;
    logic                      irq_reqep;
    logic                      wr_word_valid, rd_word_valid, irq_word_valid;
    logic                      wr_word_last, rd_word_last, irq_word_last;
    logic [`DMA_EP_WORD_W-1:0] wr_word_data;
    logic [`DMA_EP_WORD_W-1:0] rd_word_data;
    logic [`DMA_EP_WORD_W-1:0] irq_word_data;

    wr_tlp_engine u_wr (
        .clk, .rst, .wr_req, .wr_addr, .wr_data, .wr_tag, .wr_trn,
        .wr_overflow, .wr_drvn, .wr_word_valid, .wr_word_data, .wr_word_last
    );

    rd_tlp_engine u_rd (
        .clk, .rst, .rd_req, .rd_addr, .rd_tag, .rd_trn,
        .rd_overflow, .rd_drvn, .rd_word_valid, .rd_word_data, .rd_word_last
    );

    irq_msg_engine u_irq (
        .clk, .rst, .irq_req, .irq_vector, .irq_trn,
        .irq_reqep, .irq_drvn, .irq_word_valid, .irq_word_data, .irq_word_last
    );

    ep_arbiter u_arb (
        .clk, .rst,
        .wr_drvn, .rd_drvn, .irq_drvn, .irq_reqep,
        .wr_word_valid, .wr_word_data, .wr_word_last,
        .rd_word_valid, .rd_word_data, .rd_word_last,
        .irq_word_valid, .irq_word_data, .irq_word_last,
        .wr_trn, .rd_trn, .irq_trn,
        .ep_valid, .ep_data, .ep_last
    );

endmodule

// ==== tb_dma_ep.sv ====
// directed testbench for the dma endpoint transmit subsystem
// logs every endpoint packet and checks it against headers rebuilt from the layout rule
`timescale 1ns/10ps
`include "dma_ep_defs.svh"

module tb_dma_ep;

    localparam int TIMEOUT_CYC  = 200; // per packet wait
    localparam int SETTLE_CYC   = 30;  // quiet time before the exact count
    localparam int OVF_WAIT_CYC = 10;  // overflow pulse follows its strobe closely
    localparam int PAD_W        = `DMA_EP_WORD_W - 8 - `DMA_EP_ADDR_W;

    logic                        clk;
    logic                        rst;
    logic                        wr_req;
    logic [`DMA_EP_ADDR_W-1:0]   wr_addr;
    logic [`DMA_EP_WORD_W/2-1:0] wr_data;
    logic [3:0]                  wr_tag;
    logic                        rd_req;
    logic [`DMA_EP_ADDR_W-1:0]   rd_addr;
    logic [3:0]                  rd_tag;
    logic                        irq_req;
    logic [7:0]                  irq_vector;
    logic                        wr_overflow;
    logic                        rd_overflow;
    logic                        ep_valid;
    logic [`DMA_EP_WORD_W-1:0]   ep_data;
    logic                        ep_last;

    // request values per test, index = strobe order within its class
    logic [`DMA_EP_ADDR_W-1:0]   exp_wa [8];
    logic [`DMA_EP_WORD_W/2-1:0] exp_wd [8];
    logic [3:0]                  exp_wt [8];
    logic [`DMA_EP_ADDR_W-1:0]   exp_ra [8];
    logic [3:0]                  exp_rt [8];
    logic [7:0]                  exp_vec; // last vector, the one expected on ep

    // packet log filled by the monitor
    logic [`DMA_EP_WORD_W-1:0]   log_hdr [$];
    logic [`DMA_EP_WORD_W-1:0]   log_dat [$];
    int                          log_len [$];
    logic [`DMA_EP_WORD_W-1:0]   cur_hdr;
    logic [`DMA_EP_WORD_W-1:0]   cur_dat;
    int                          cur_len;

    int errs;       // errors in the running test
    int pass_cnt;
    int fail_cnt;
    int wr_ovf_cnt; // overflow pulses since reset
    int rd_ovf_cnt;

    dma_ep_top dut0 (
        .clk, .rst,
        .wr_req, .wr_addr, .wr_data, .wr_tag,
        .rd_req, .rd_addr, .rd_tag,
        .irq_req, .irq_vector,
        .wr_overflow, .rd_overflow,
        .ep_valid, .ep_data, .ep_last
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz
    end

    ////////////////////////////////////////////////////////////////////////////
    // monitor, one word per cycle, packet closes on ep_last
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            cur_len = 0;
        end else begin
            if (wr_overflow) begin
                wr_ovf_cnt++;
            end
            if (rd_overflow) begin
                rd_ovf_cnt++;
            end
            if (ep_valid) begin
                if (cur_len == 0) begin
                    cur_hdr = ep_data;
                end else begin
                    cur_dat = ep_data; // second word of a write
                end
                cur_len++;
                if (ep_last) begin
                    log_hdr.push_back(cur_hdr);
                    log_dat.push_back((cur_len > 1) ? cur_dat : '0);
                    log_len.push_back(cur_len);
                    cur_len = 0;
                end
            end
        end
    end

    // header word: type, tag, zero pad, address or vector
    function automatic logic [`DMA_EP_WORD_W-1:0] make_hdr(input logic [3:0] t,
            input logic [3:0] tag, input logic [`DMA_EP_ADDR_W-1:0] addr);
        return {t, tag, {PAD_W{1'b0}}, addr};
    endfunction

    task automatic check_word(input string name, input string what,
            input logic [`DMA_EP_WORD_W-1:0] exp, input logic [`DMA_EP_WORD_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %s %s: expected %h, actual %h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk); // two cycles held
        rst <= 1'b0;
        log_hdr.delete();
        log_dat.delete();
        log_len.delete();
        wr_ovf_cnt = 0;
        rd_ovf_cnt = 0;
    endtask

    task automatic fill_reqs();
        for (int i = 0; i < 8; i++) begin
            exp_wa[i] = $urandom;
            exp_wd[i] = $urandom;
            exp_wt[i] = 4'($urandom);
            exp_ra[i] = $urandom;
            exp_rt[i] = 4'($urandom);
        end
        exp_vec = 8'($urandom);
    endtask

    // one cycle of user-side strobes
    task automatic drive_cycle(input bit w, input int wi, input bit r, input int ri,
            input bit i, input logic [7:0] v);
        @(posedge clk);
        wr_req     <= w;
        wr_addr    <= exp_wa[wi];
        wr_data    <= exp_wd[wi];
        wr_tag     <= exp_wt[wi];
        rd_req     <= r;
        rd_addr    <= exp_ra[ri];
        rd_tag     <= exp_rt[ri];
        irq_req    <= i;
        irq_vector <= v;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 0, 1'b0, 0, 1'b0, 8'h00);
    endtask

    task automatic wait_packets(input string name, input int n);
        int cyc;
        cyc = 0;
        while (log_hdr.size() < n && cyc < TIMEOUT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (log_hdr.size() < n) begin
            $display("test %s: timeout, expected packet never arrived (%0d of %0d seen)",
                     name, log_hdr.size(), n);
            errs++;
        end else begin
            repeat (SETTLE_CYC) @(posedge clk); // catch extra packets
            if (log_hdr.size() != n) begin
                $display("** Error %s packet count: expected %0d, actual %0d",
                         name, n, log_hdr.size());
                errs++;
            end
        end
    endtask

    // packets of one type, in strobe order, against rebuilt words
    task automatic check_class(input string name, input logic [3:0] t, input int n);
        int                        k;
        logic [`DMA_EP_WORD_W-1:0] hdr;
        logic [`DMA_EP_WORD_W-1:0] eh;
        logic [`DMA_EP_WORD_W-1:0] ed;
        int                        el;
        k = 0;
        for (int p = 0; p < log_hdr.size(); p++) begin
            hdr = log_hdr[p];
            if (hdr[63:60] == t) begin
                if (k < n) begin
                    if (t == dma_ep_pkg::TLP_MWR) begin
                        eh = make_hdr(t, exp_wt[k], exp_wa[k]);
                        ed = {{(`DMA_EP_WORD_W/2){1'b0}}, exp_wd[k]};
                        el = 2;
                    end else if (t == dma_ep_pkg::TLP_MRD) begin
                        eh = make_hdr(t, exp_rt[k], exp_ra[k]);
                        ed = '0;
                        el = 1;
                    end else begin
                        eh = make_hdr(t, 4'h0, {{(`DMA_EP_ADDR_W-8){1'b0}}, exp_vec});
                        ed = '0;
                        el = 1;
                    end
                    check_word(name, "header", eh, hdr);
                    check_word(name, "data word", ed, log_dat[p]);
                    check_word(name, "word count", 64'(el), 64'(log_len[p]));
                end
                k++;
            end
        end
        check_word(name, "packets of one type", 64'(n), 64'(k));
    endtask

    task automatic finish_test(input string name);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d errors", name, errs);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_single_write();
        errs = 0;
        fill_reqs();
        apply_reset();
        drive_cycle(1'b1, 0, 1'b0, 0, 1'b0, 8'h00);
        idle_cycle();
        wait_packets("single_write", 1);
        check_class("single_write", dma_ep_pkg::TLP_MWR, 1);
        finish_test("single_write");
    endtask

    task automatic test_single_read();
        errs = 0;
        fill_reqs();
        apply_reset();
        drive_cycle(1'b0, 0, 1'b1, 0, 1'b0, 8'h00);
        idle_cycle();
        wait_packets("single_read", 1);
        check_class("single_read", dma_ep_pkg::TLP_MRD, 1);
        finish_test("single_read");
    endtask

    task automatic test_fairness();
        logic [3:0] prev;
        logic [3:0] et;
        errs = 0;
        fill_reqs();
        apply_reset();
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, i, 1'b1, i, 1'b0, 8'h00);
        end
        idle_cycle();
        wait_packets("fairness", 8);
        // first read turn lands before any strobe is queued, so either class may lead
        for (int p = 1; p < log_hdr.size() && p < 8; p++) begin
            prev = log_hdr[p-1][63:60];
            et   = (prev == dma_ep_pkg::TLP_MRD) ? dma_ep_pkg::TLP_MWR : dma_ep_pkg::TLP_MRD;
            check_word("fairness", "packet type", 64'(et), 64'(log_hdr[p][63:60]));
        end
        check_class("fairness", dma_ep_pkg::TLP_MWR, 4);
        check_class("fairness", dma_ep_pkg::TLP_MRD, 4);
        finish_test("fairness");
    endtask

    task automatic test_irq();
        errs = 0;
        fill_reqs();
        apply_reset();
        // two vectors before the irq slot, only the second counts
        drive_cycle(1'b1, 0, 1'b1, 0, 1'b1, exp_vec ^ 8'hff);
        drive_cycle(1'b1, 1, 1'b1, 1, 1'b1, exp_vec);
        idle_cycle();
        wait_packets("irq", 5);
        check_class("irq", dma_ep_pkg::TLP_MSG, 1);
        check_class("irq", dma_ep_pkg::TLP_MWR, 2); // word count catches a split
        check_class("irq", dma_ep_pkg::TLP_MRD, 2);
        finish_test("irq");
    endtask

    task automatic test_overflow();
        int kept;
        int cyc;
        errs = 0;
        fill_reqs();
        // write side, one read packet delays the next write turn
        apply_reset();
        drive_cycle(1'b0, 0, 1'b1, 0, 1'b0, 8'h00);
        idle_cycle();
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b1, i, 1'b0, 0, 1'b0, 8'h00);
        end
        idle_cycle();
        cyc = 0;
        while (wr_ovf_cnt == 0 && cyc < OVF_WAIT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (wr_ovf_cnt == 0) begin
            $display("test overflow: wr_overflow never pulsed with the write queue full");
            errs++;
        end
        kept = 5 - wr_ovf_cnt;
        wait_packets("overflow", kept + 1);
        check_class("overflow", dma_ep_pkg::TLP_MWR, kept);
        check_class("overflow", dma_ep_pkg::TLP_MRD, 1);
        // read side, a write packet holds the port
        apply_reset();
        drive_cycle(1'b1, 0, 1'b0, 0, 1'b0, 8'h00);
        for (int i = 0; i < 5; i++) begin
            drive_cycle(1'b0, 0, 1'b1, i, 1'b0, 8'h00);
        end
        idle_cycle();
        cyc = 0;
        while (rd_ovf_cnt == 0 && cyc < OVF_WAIT_CYC) begin
            @(posedge clk);
            cyc++;
        end
        if (rd_ovf_cnt == 0) begin
            $display("test overflow: rd_overflow never pulsed with the read queue full");
            errs++;
        end
        kept = 5 - rd_ovf_cnt;
        wait_packets("overflow", kept + 1);
        check_class("overflow", dma_ep_pkg::TLP_MRD, kept);
        check_class("overflow", dma_ep_pkg::TLP_MWR, 1);
        finish_test("overflow");
    endtask

    initial begin
        rst        = 1'b1;
        wr_req     = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        wr_tag     = '0;
        rd_req     = 1'b0;
        rd_addr    = '0;
        rd_tag     = '0;
        irq_req    = 1'b0;
        irq_vector = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        wr_ovf_cnt = 0;
        rd_ovf_cnt = 0;
        void'($urandom(69)); // seeds the run
        test_single_write();
        test_single_read();
        test_fairness();
        test_irq();
        test_overflow();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dma_ep_top.f ====
+incdir+.
dma_ep_pkg.sv
ep_arbiter.sv
wr_tlp_engine.sv
rd_tlp_engine.sv
irq_msg_engine.sv
dma_ep_top.sv
tb_dma_ep.sv

// ==== Bender.yml ====
package:
  name: dma_ep_top

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dma_ep_pkg.sv
      - ep_arbiter.sv
      - wr_tlp_engine.sv
      - rd_tlp_engine.sv
      - irq_msg_engine.sv
      - dma_ep_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dma_ep.sv
